// File: verilog/duckPkg.sv
package duckPkg;

	localparam int coordW = 10; // Screen coordinate
	localparam int frameW = 6;  // Sprite frame index
	localparam int colorW = 2;  // Black 0, red 1, pink 2, 3 as black
	localparam int headW = 3;

	// Defaults for the top-level parameters
	localparam int defXMax = 640;
	localparam int defYMax = 460;
	localparam int defHitFrames = 16;
	localparam int defCycleBase = 3;

	// Heading word read as a code or as direction bits
	// In the north half the low bit marks a level heading. The south half
	// has no level headings, so its low bit carries east instead
	typedef union packed
	{
		logic [headW-1:0] raw;
		struct packed
		{
			logic south; // Moves down
			logic east;  // Moves right, north headings
			logic low;   // Level if north, east if south
		} f;
	} headingU;

	localparam logic [headW-1:0] hdNW = 3'd0;
	localparam logic [headW-1:0] hdW = 3'd1;
	localparam logic [headW-1:0] hdNE = 3'd2;
	localparam logic [headW-1:0] hdE = 3'd3;
	localparam logic [headW-1:0] hdSW = 3'd4;
	localparam logic [headW-1:0] hdSE = 3'd5;

	localparam logic [3:0] stepLevelX = 4'd15;
	localparam logic [3:0] stepLevelY = 4'd2;
	localparam logic [3:0] stepDiagX = 4'd12;
	localparam logic [3:0] stepDiagY = 4'd10;

	localparam logic [coordW-1:0] startY = 10'd300;
	localparam logic [coordW-1:0] resetX = 10'd400;

	localparam logic [frameW-1:0] baseNW = 6'd11; // Also SW
	localparam logic [frameW-1:0] baseW = 6'd15;
	localparam logic [frameW-1:0] baseNE = 6'd0;  // Also SE
	localparam logic [frameW-1:0] baseE = 6'd4;
	localparam logic [frameW-1:0] hitWest = 6'd19;
	localparam logic [frameW-1:0] hitEast = 6'd8;
	localparam logic [frameW-1:0] colorStride = 6'd20;

	function automatic logic isEast(headingU h);
		return h.f.south ? h.f.low : h.f.east;
	endfunction

	function automatic logic isLevel(headingU h);
		return !h.f.south && h.f.low; // Only W and E
	endfunction

endpackage

// File: verilog/motionIf.sv
`timescale 1ns/1ns

interface motionIf;
	import duckPkg::*;

	logic load;                // Place duck at loadX, startY
	logic [coordW-1:0] loadX;
	logic advance;             // One step per clock while high
	headingU heading;
	logic atWall;
	logic atTop;
	logic atBottom;

	modport seq
	(
		output load, loadX, advance, heading,
		input atWall, atTop, atBottom
	);

	modport integ
	(
		input load, loadX, advance, heading,
		output atWall, atTop, atBottom
	);

endinterface

// File: verilog/spriteIf.sv
`timescale 1ns/1ns

interface spriteIf;
	import duckPkg::*;

	logic restart;             // Reload base, clear wing phase
	logic flying;              // Phase advances while high
	logic hitPose;
	headingU heading;
	logic [colorW-1:0] color;

	modport seq
	(
		output restart, flying, hitPose, heading, color
	);

	modport sel
	(
		input restart, flying, hitPose, heading, color
	);

endinterface

// File: verilog/flightSequencer.sv
`timescale 1ns/1ns

module flightSequencer #(
	parameter int hitFrames = duckPkg::defHitFrames,
	parameter int cycleBase = duckPkg::defCycleBase
) (
	input logic ANIM_Clk,
	input logic Reset,
	input logic run,
	input logic duckKill,
	input logic [duckPkg::colorW-1:0] colorRand,
	input duckPkg::headingU headingRand,
	input logic [1:0] repeatsRand,
	input logic [duckPkg::coordW-1:0] startXRand,
	motionIf.seq mot,
	spriteIf.seq spr,
	output logic duckActive,
	output logic [duckPkg::colorW-1:0] duckColor,
	output logic bounce
);
	import duckPkg::*;

	localparam int cntW = $clog2(cycleBase + 4) + 1;
	localparam int hitW = $clog2(hitFrames) + 1;

	enum logic [2:0] {stIdle, stStart, stFly, stBounce, stHit} state, nextState;

	headingU heading;
	logic [colorW-1:0] colorReg;
	logic [coordW-1:0] startX;
	logic [1:0] wingPhase;        // Tracks the selector's phase
	logic [cntW-1:0] cycleCount;  // Complete wing cycles since last turn
	logic [cntW-1:0] cycleTarget;
	logic [hitW-1:0] hitCount;
	logic turnPending;            // New heading waits one clock for restart
	logic lastBounce;
	logic wallHit;
	logic hitDone;
	logic restartNow;
	logic cycleEnd;
	logic courseChange;

	// Random codes 6 and 7 fly east
	function automatic headingU cleanHeading(headingU h);
		headingU c;
		c.raw = (h.raw > hdSE) ? hdE : h.raw;
		return c;
	endfunction

	function automatic headingU reflect(headingU h, logic top, logic bottom);
		headingU r;
		case (h.raw)
			hdW: r.raw = top ? hdSW : hdE;
			hdE: r.raw = top ? hdSE : hdW;
			hdNW: r.raw = top ? hdSW : hdNE;
			hdNE: r.raw = top ? hdSE : hdNW;
			hdSW: r.raw = bottom ? hdNW : hdSE;
			hdSE: r.raw = bottom ? hdNE : hdSW;
			default: r.raw = hdE;
		endcase
		return r;
	endfunction

	// Still on the wall right after a bounce, so skip that clock
	assign wallHit = mot.atWall && !lastBounce;
	assign hitDone = (hitCount == hitW'(hitFrames - 1));
	assign cycleTarget = cntW'(repeatsRand) + cntW'(cycleBase);
	assign restartNow = (state == stStart) || (state == stBounce) ||
		((state == stFly) && turnPending);
	assign cycleEnd = (state == stFly) && (nextState == stFly) && !restartNow &&
		(wingPhase == 2'd3);
	assign courseChange = cycleEnd && (cycleCount + cntW'(1) == cycleTarget);

	always_comb
	begin
		nextState = state;
		case (state)
			stIdle: if (run) nextState = stStart;
			stStart: nextState = stFly;
			stFly:
			begin
				if (duckKill)
					nextState = stHit; // Kill wins over a wall
				else if (wallHit)
					nextState = stBounce;
			end
			stBounce: nextState = stFly;
			stHit: if (hitDone) nextState = stStart;
			default: nextState = stIdle;
		endcase
	end

	always_ff @(posedge ANIM_Clk or posedge Reset)
	begin
		if (Reset)
		begin
			state <= stIdle;
			heading <= '0;
			colorReg <= '0;
			wingPhase <= '0;
			cycleCount <= '0;
			hitCount <= '0;
			turnPending <= 1'b0;
			lastBounce <= 1'b0;
		end
		else
		begin
			state <= nextState;
			lastBounce <= (state == stBounce);
			turnPending <= courseChange;

			if (nextState == stStart) // From idle or after a hit
			begin
				heading <= cleanHeading(headingRand);
				colorReg <= colorRand;
			end
			else if (nextState == stBounce)
				heading <= reflect(heading, mot.atTop, mot.atBottom);
			else if (courseChange)
				heading <= cleanHeading(headingRand);

			if (restartNow)
				wingPhase <= '0;
			else if (state == stFly)
				wingPhase <= wingPhase + 2'd1;

			if ((state == stStart) || (nextState == stBounce) || courseChange)
				cycleCount <= '0;
			else if (cycleEnd)
				cycleCount <= cycleCount + cntW'(1);

			hitCount <= (state == stHit) ? hitCount + hitW'(1) : '0;
		end
	end

	always_ff @(posedge ANIM_Clk)
	begin
		if (nextState == stStart)
			startX <= startXRand;
	end

	assign mot.load = (state == stStart);
	assign mot.loadX = startX;
	assign mot.advance = (state == stFly);
	assign mot.heading = heading;

	assign spr.restart = restartNow;
	assign spr.flying = (state == stFly);
	assign spr.hitPose = (state == stHit); // Frozen duck
	assign spr.heading = heading;
	assign spr.color = colorReg;

	assign duckActive = (state != stIdle);
	assign duckColor = colorReg;
	assign bounce = (state == stBounce);

endmodule

// File: verilog/positionIntegrator.sv
`timescale 1ns/1ns

module positionIntegrator #(
	parameter int xMax = duckPkg::defXMax,
	parameter int yMax = duckPkg::defYMax
) (
	input logic ANIM_Clk,
	input logic Reset,
	motionIf.integ mot,
	output logic [duckPkg::coordW-1:0] duckX,
	output logic [duckPkg::coordW-1:0] duckY
);
	import duckPkg::*;

	localparam logic [coordW-1:0] xLim = coordW'(xMax);
	localparam logic [coordW-1:0] yLim = coordW'(yMax);

	logic [coordW-1:0] stepX;
	logic [coordW-1:0] stepY;
	logic [coordW:0] sumX;   // One spare bit for the carry
	logic [coordW:0] sumY;
	logic [coordW-1:0] nextX;
	logic [coordW-1:0] nextY;

	always_comb
	begin
		stepX = isLevel(mot.heading) ? coordW'(stepLevelX) : coordW'(stepDiagX);
		stepY = isLevel(mot.heading) ? coordW'(stepLevelY) : coordW'(stepDiagY);
		sumX = {1'b0, duckX} + {1'b0, stepX};
		sumY = {1'b0, duckY} + {1'b0, stepY};

		if (isEast(mot.heading))
			nextX = (sumX > {1'b0, xLim}) ? xLim : sumX[coordW-1:0];
		else
			nextX = (duckX < stepX) ? '0 : duckX - stepX;

		if (mot.heading.f.south)
			nextY = (sumY > {1'b0, yLim}) ? yLim : sumY[coordW-1:0];
		else
			nextY = (duckY < stepY) ? '0 : duckY - stepY; // Up toward 0
	end

	always_ff @(posedge ANIM_Clk or posedge Reset)
	begin
		if (Reset)
		begin
			duckX <= resetX;
			duckY <= startY;
		end
		else if (mot.load)
		begin
			duckX <= mot.loadX;
			duckY <= startY;
		end
		else if (mot.advance)
		begin
			duckX <= nextX;
			duckY <= nextY;
		end
	end

	// Flags from the registered position
	assign mot.atTop = (duckY == '0);
	assign mot.atBottom = (duckY == yLim);
	assign mot.atWall = (duckX == '0) || (duckX == xLim) || mot.atTop || mot.atBottom;

endmodule

// File: verilog/spriteFrameSelect.sv
`timescale 1ns/1ns

module spriteFrameSelect
(
	input logic ANIM_Clk,
	input logic Reset,
	spriteIf.sel spr,
	output logic [duckPkg::frameW-1:0] duckFrame
);
	import duckPkg::*;

	logic [frameW-1:0] colorOffset;
	logic [frameW-1:0] dirBase;
	logic [frameW-1:0] flyBase;
	logic [frameW-1:0] hitBase;
	logic [frameW-1:0] baseReg;  // Flight base held between restarts
	logic [1:0] phase;           // Wing phase 0 to 3
	logic [1:0] phaseNext;

	always_comb
	begin
		case (spr.color)
			2'd1: colorOffset = colorStride;         // Red
			2'd2: colorOffset = frameW'(2 * colorStride); // Pink
			default: colorOffset = '0;               // Black and code 3
		endcase

		// South headings share the diagonal sprites of the north ones
		if (isLevel(spr.heading))
			dirBase = isEast(spr.heading) ? baseE : baseW;
		else
			dirBase = isEast(spr.heading) ? baseNE : baseNW;

		flyBase = dirBase + colorOffset;
		hitBase = (isEast(spr.heading) ? hitEast : hitWest) + colorOffset;
	end

	assign phaseNext = phase + 2'd1;

	always_ff @(posedge ANIM_Clk or posedge Reset)
	begin
		if (Reset)
		begin
			baseReg <= '0;
			phase <= '0;
			duckFrame <= '0;
		end
		else if (spr.restart)
		begin
			baseReg <= flyBase;
			phase <= '0;
			duckFrame <= flyBase;
		end
		else if (spr.hitPose)
			duckFrame <= hitBase; // Phase holds through the hit
		else if (spr.flying)
		begin
			phase <= phaseNext;
			duckFrame <= baseReg + frameW'(phaseNext);
		end
	end

endmodule

// File: verilog/duckAnimator.sv
`timescale 1ns/1ns

module duckAnimator #(
	parameter int xMax = duckPkg::defXMax,
	parameter int yMax = duckPkg::defYMax,
	parameter int hitFrames = duckPkg::defHitFrames,
	parameter int cycleBase = duckPkg::defCycleBase
) (
	input logic ANIM_Clk,
	input logic Reset,
	input logic run,
	input logic duckKill,
	input logic [duckPkg::colorW-1:0] colorRand,
	input logic [duckPkg::headW-1:0] headingRand,
	input logic [1:0] repeatsRand,
	input logic [duckPkg::coordW-1:0] startXRand,
	output logic [duckPkg::coordW-1:0] duckX,
	output logic [duckPkg::coordW-1:0] duckY,
	output logic [duckPkg::frameW-1:0] duckFrame,
	output logic [duckPkg::colorW-1:0] duckColor,
	output logic duckActive,
	output logic bounce
);

	motionIf motion();
	spriteIf sprite();

	flightSequencer #(.hitFrames(hitFrames), .cycleBase(cycleBase)) seq0
	(
		.ANIM_Clk(ANIM_Clk),
		.Reset(Reset),
		.run(run),
		.duckKill(duckKill),
		.colorRand(colorRand),
		.headingRand(headingRand), // Raw code into the heading union
		.repeatsRand(repeatsRand),
		.startXRand(startXRand),
		.mot(motion.seq),
		.spr(sprite.seq),
		.duckActive(duckActive),
		.duckColor(duckColor),
		.bounce(bounce)
	);

	positionIntegrator #(.xMax(xMax), .yMax(yMax)) integ0
	(
		.ANIM_Clk(ANIM_Clk),
		.Reset(Reset),
		.mot(motion.integ),
		.duckX(duckX),
		.duckY(duckY)
	);

	spriteFrameSelect sel0
	(
		.ANIM_Clk(ANIM_Clk),
		.Reset(Reset),
		.spr(sprite.sel),
		.duckFrame(duckFrame)
	);

endmodule

// File: tests/duckAnimator_sva.sv
`timescale 1ns/1ns

module duckAnimator_sva #(
	parameter int xMax = duckPkg::defXMax,
	parameter int yMax = duckPkg::defYMax
) (
	input logic ANIM_Clk,
	input logic Reset,
	input logic bounce,
	input logic duckActive,
	input logic [duckPkg::coordW-1:0] duckX,
	input logic [duckPkg::coordW-1:0] duckY
);

	bouncePulse: assert property (@(posedge ANIM_Clk) disable iff (Reset) bounce |=> !bounce)
		else $error("bounce held for two cycles");

	idleInReset: assert property (@(posedge ANIM_Clk) Reset |-> !duckActive)
		else $error("duckActive high during reset");

	xInRange: assert property (@(posedge ANIM_Clk) disable iff (Reset) duckX <= xMax)
		else $error("duckX beyond limit");

	yInRange: assert property (@(posedge ANIM_Clk) disable iff (Reset) duckY <= yMax)
		else $error("duckY beyond limit");

endmodule

bind duckAnimator duckAnimator_sva #(.xMax(xMax), .yMax(yMax)) sva0
(
	.ANIM_Clk(ANIM_Clk),
	.Reset(Reset),
	.bounce(bounce),
	.duckActive(duckActive),
	.duckX(duckX),
	.duckY(duckY)
);

// File: tests/duckAnimatorTb.sv
`timescale 1ns/1ns

module duckAnimatorTb;
	import duckPkg::*;

	localparam int xMaxTb = 640;
	localparam int yMaxTb = 460;
	localparam int hitFramesTb = 16;
	localparam int cycleBaseTb = 3;
	localparam int testCycles = 30 + 6 * 25 + 35 + 50 + 40; // Rough length of all tests
	localparam int watchdogNs = (testCycles + 300) * 40;

	logic ANIM_Clk;
	logic Reset;
	logic run;
	logic duckKill;
	logic [colorW-1:0] colorRand;
	logic [headW-1:0] headingRand;
	logic [1:0] repeatsRand;
	logic [coordW-1:0] startXRand;
	logic [coordW-1:0] duckX;
	logic [coordW-1:0] duckY;
	logic [frameW-1:0] duckFrame;
	logic [colorW-1:0] duckColor;
	logic duckActive;
	logic bounce;

	integer seed;
	int errors;
	int testsRun;
	int testsFailed;
	int curX;
	int curY;

	duckAnimator #(.xMax(xMaxTb), .yMax(yMaxTb), .hitFrames(hitFramesTb),
		.cycleBase(cycleBaseTb)) dut0
	(
		.ANIM_Clk(ANIM_Clk),
		.Reset(Reset),
		.run(run),
		.duckKill(duckKill),
		.colorRand(colorRand),
		.headingRand(headingRand),
		.repeatsRand(repeatsRand),
		.startXRand(startXRand),
		.duckX(duckX),
		.duckY(duckY),
		.duckFrame(duckFrame),
		.duckColor(duckColor),
		.duckActive(duckActive),
		.bounce(bounce)
	);

	always #20 ANIM_Clk = ~ANIM_Clk;

	// Heading codes 0 to 5 are NW W NE E SW SE
	function automatic bit goesEast(int h);
		return (h == 2) || (h == 3) || (h == 5);
	endfunction

	function automatic bit goesSouth(int h);
		return (h == 4) || (h == 5);
	endfunction

	function automatic int stepOfX(int h);
		return (h == 1 || h == 3) ? 15 : 12;
	endfunction

	function automatic int stepOfY(int h);
		return (h == 1 || h == 3) ? 2 : 10;
	endfunction

	function automatic int moveCoord(int pos, int step, bit plus, int lim);
		if (plus)
			return (pos + step > lim) ? lim : pos + step;
		return (pos < step) ? 0 : pos - step;
	endfunction

	function automatic int colorOffsetOf(int c);
		return (c == 1 || c == 2) ? 20 * c : 0; // Code 3 draws black
	endfunction

	function automatic int flyBaseOf(int h, int c);
		int b;
		case (h)
			1: b = 15;
			3: b = 4;
			2, 5: b = 0;
			default: b = 11;
		endcase
		return b + colorOffsetOf(c);
	endfunction

	function automatic int hitBaseOf(int h, int c);
		return (goesEast(h) ? 8 : 19) + colorOffsetOf(c);
	endfunction

	function automatic int reflectOf(int h, bit top, bit bottom);
		case (h)
			1: return top ? 4 : 3;
			3: return top ? 5 : 1;
			0: return top ? 4 : 2;
			2: return top ? 5 : 0;
			4: return bottom ? 0 : 5;
			default: return bottom ? 2 : 4;
		endcase
	endfunction

	task automatic checkCoord(string name, logic [coordW-1:0] got, logic [coordW-1:0] exp);
		if (got !== exp)
		begin
			$display("MISMATCH %s got %h expected %h at %0t", name, got, exp, $time);
			errors++;
		end
	endtask

	task automatic checkFrame(string name, logic [frameW-1:0] got, logic [frameW-1:0] exp);
		if (got !== exp)
		begin
			$display("MISMATCH %s got %h expected %h at %0t", name, got, exp, $time);
			errors++;
		end
	endtask

	task automatic checkColor(string name, logic [colorW-1:0] got, logic [colorW-1:0] exp);
		if (got !== exp)
		begin
			$display("MISMATCH %s got %h expected %h at %0t", name, got, exp, $time);
			errors++;
		end
	endtask

	task automatic checkFlag(string name, logic got, logic exp);
		if (got !== exp)
		begin
			$display("MISMATCH %s got %h expected %h at %0t", name, got, exp, $time);
			errors++;
		end
	endtask

	task automatic nextSample();
		@(posedge ANIM_Clk);
		@(negedge ANIM_Clk); // Outputs settled
	endtask

	task automatic resetDut();
		@(posedge ANIM_Clk);
		Reset <= 1'b1;
		run <= 1'b0;
		duckKill <= 1'b0;
		repeat (5) @(posedge ANIM_Clk);
		Reset <= 1'b0;
		@(negedge ANIM_Clk);
	endtask

	task automatic reportTest(string name, int errBefore);
		testsRun++;
		if (errors != errBefore)
		begin
			testsFailed++;
			$display("test %s: failed with %0d errors", name, errors - errBefore);
		end
		else
			$display("test %s: ok", name);
	endtask

	// Start flight and check the load
	// laterH goes onto headingRand once the start is latched
	task automatic startDuck(int x, int h, int c, int laterH);
		int waited;
		@(posedge ANIM_Clk);
		colorRand <= c[colorW-1:0];
		headingRand <= h[headW-1:0];
		startXRand <= x[coordW-1:0];
		run <= 1'b1;
		waited = 0;
		do
		begin
			nextSample();
			waited++;
		end
		while (!duckActive && waited < 3);
		if (!duckActive)
		begin
			$display("duck did not start within 3 cycles of run");
			errors++;
		end
		@(posedge ANIM_Clk);
		run <= 1'b0;
		headingRand <= laterH[headW-1:0];
		@(negedge ANIM_Clk);
		checkCoord("duckX", duckX, x[coordW-1:0]);
		checkCoord("duckY", duckY, 10'd300);
		checkFrame("duckFrame", duckFrame, frameW'(flyBaseOf(h, c)));
		checkColor("duckColor", duckColor, c[colorW-1:0]);
		checkFlag("duckActive", duckActive, 1'b1);
		curX = x;
		curY = 300;
	endtask

	// One flight step against the step rule
	task automatic checkStep(int h, int c, int phase);
		nextSample();
		curX = moveCoord(curX, stepOfX(h), goesEast(h), xMaxTb);
		curY = moveCoord(curY, stepOfY(h), goesSouth(h), yMaxTb);
		checkCoord("duckX", duckX, curX[coordW-1:0]);
		checkCoord("duckY", duckY, curY[coordW-1:0]);
		checkFrame("duckFrame", duckFrame, frameW'(flyBaseOf(h, c) + phase));
	endtask

	task automatic resetAndStart();
		int e;
		int x;
		int h;
		int c;
		e = errors;
		resetDut();
		checkCoord("duckX", duckX, 10'd400);
		checkCoord("duckY", duckY, 10'd300);
		checkFrame("duckFrame", duckFrame, 6'd0);
		checkFlag("duckActive", duckActive, 1'b0);
		x = 100 + ($unsigned($random(seed)) % 400);
		h = $unsigned($random(seed)) % 6;
		c = $unsigned($random(seed)) % 4;
		startDuck(x, h, c, h);
		reportTest("resetAndStart", e);
	endtask

	task automatic flightStepping();
		int e;
		int c;
		e = errors;
		for (int h = 0; h < 6; h++)
		begin
			resetDut();
			c = $unsigned($random(seed)) % 4;
			startDuck(320, h, c, h);
			for (int i = 1; i <= 8; i++)
				checkStep(h, c, i % 4);
		end
		reportTest("flightStepping", e);
	endtask

	task automatic wallBounce();
		int e;
		int c;
		int newH;
		int i;
		bit seen;
		e = errors;
		resetDut();
		@(posedge ANIM_Clk);
		repeatsRand <= 2'd3;
		c = $unsigned($random(seed)) % 4;
		startDuck(615, 3, c, 3);
		seen = 0;
		newH = 3;
		for (i = 1; i <= 8 && !seen; i++)
		begin
			newH = reflectOf(3, curY == 0, curY == yMaxTb);
			checkStep(3, c, i % 4);
			seen = bounce;
		end
		if (!seen)
		begin
			$display("no bounce pulse seen at the right wall");
			errors++;
		end
		nextSample(); // Position holds in the bounce cycle
		checkFlag("bounce", bounce, 1'b0);
		checkCoord("duckX", duckX, curX[coordW-1:0]);
		checkCoord("duckY", duckY, curY[coordW-1:0]);
		checkFrame("duckFrame", duckFrame, frameW'(flyBaseOf(newH, c)));
		for (i = 1; i <= 3; i++)
		begin
			checkStep(newH, c, i);
			checkFlag("bounce", bounce, 1'b0);
		end
		reportTest("wallBounce", e);
	endtask

	task automatic hitAndRestart();
		int e;
		int c;
		int waited;
		logic [coordW-1:0] frozenX;
		logic [coordW-1:0] frozenY;
		bit reloaded;
		e = errors;
		resetDut();
		c = $unsigned($random(seed)) % 4;
		startDuck(300, 2, c, 2);
		checkStep(2, c, 1);
		checkStep(2, c, 2);
		@(posedge ANIM_Clk);
		duckKill <= 1'b1;
		startXRand <= 10'd150;
		@(posedge ANIM_Clk); // Kill sampled here
		duckKill <= 1'b0;
		// The duck still steps on the drive edge and on the kill edge
		for (int k = 0; k < 2; k++)
		begin
			curX = moveCoord(curX, stepOfX(2), goesEast(2), xMaxTb);
			curY = moveCoord(curY, stepOfY(2), goesSouth(2), yMaxTb);
		end
		frozenX = curX[coordW-1:0];
		frozenY = curY[coordW-1:0];
		waited = 0;
		reloaded = 0;
		while (!reloaded && waited <= hitFramesTb + 3)
		begin
			@(posedge ANIM_Clk);
			@(negedge ANIM_Clk);
			waited++;
			reloaded = (duckX == 10'd150) && (duckY == 10'd300);
			if (!reloaded)
			begin
				checkCoord("duckX", duckX, frozenX);
				checkCoord("duckY", duckY, frozenY);
				checkFrame("duckFrame", duckFrame, frameW'(hitBaseOf(2, c)));
			end
		end
		if (!reloaded)
		begin
			$display("duck did not restart within %0d cycles after the hit", hitFramesTb + 3);
			errors++;
		end
		else
			checkFrame("duckFrame", duckFrame, frameW'(flyBaseOf(2, c)));
		reportTest("hitAndRestart", e);
	endtask

	task automatic courseChange();
		int e;
		int c;
		int turnStep;
		e = errors;
		resetDut();
		@(posedge ANIM_Clk);
		repeatsRand <= 2'd1;
		c = $unsigned($random(seed)) % 4;
		turnStep = (1 + cycleBaseTb) * 4;
		startDuck(100, 2, c, 6); // Random code 6 must fly east
		for (int i = 1; i <= turnStep; i++)
			checkStep(2, c, i % 4);
		for (int i = 0; i < 3; i++)
			checkStep(3, c, i);
		reportTest("courseChange", e);
	endtask

	initial
	begin
		#(watchdogNs);
		$display("watchdog timeout, the tests did not finish in time");
		$display("SIMULATION FAILED");
		$finish;
	end

	initial
	begin
		seed = 32'h83b11704;
		errors = 0;
		testsRun = 0;
		testsFailed = 0;
		ANIM_Clk = 1'b0;
		Reset = 1'b1;
		run = 1'b0;
		duckKill = 1'b0;
		colorRand = '0;
		headingRand = '0;
		repeatsRand = 2'd3;
		startXRand = '0;
		resetAndStart();
		flightStepping();
		wallBounce();
		hitAndRestart();
		courseChange();
		$display("tests run %0d, failed %0d, errors %0d", testsRun, testsFailed, errors);
		if (errors == 0)
			$display("SIMULATION PASSED");
		else
			$display("SIMULATION FAILED");
		$finish;
	end

endmodule

// File: sources.f
verilog/duckPkg.sv
verilog/motionIf.sv
verilog/spriteIf.sv
verilog/flightSequencer.sv
verilog/positionIntegrator.sv
verilog/spriteFrameSelect.sv
verilog/duckAnimator.sv
tests/duckAnimator_sva.sv
tests/duckAnimatorTb.sv

// File: Makefile
VERILATOR ?= verilator
TOP ?= duckAnimatorTb
OBJDIR ?= obj_dir
FLIST ?= sources.f
VFLAGS ?= --binary --timing --assert -Wno-fatal
PASSTEXT ?= SIMULATION PASSED

SIMBIN = $(OBJDIR)/V$(TOP)

.PHONY: all compile run clean

all: run

compile: $(SIMBIN)

$(SIMBIN): $(FLIST) $(shell cat $(FLIST))
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJDIR) -f $(FLIST)

run: $(SIMBIN)
	@out="$$(./$(SIMBIN))"; \
	echo "$$out"; \
	echo "$$out" | grep -q "$(PASSTEXT)"

clean:
	rm -rf $(OBJDIR)
